// File: mem_system_testdata.txt
// Columns: opcode (1 read, 2 write), byte address, data
// Data is the write data for writes and the expected read data for reads
2 0828 a1a1
1 0828 a1a1
1 0220 0000
1 0222 0000
2 102a b2b2
2 182c c3c3
1 0828 a1a1
1 082a 0000
1 102a b2b2
1 0829 0000
2 182d dead
1 182c c3c3
1 1828 0000
2 0220 5555
1 0220 5555

// File: vlog.f
mem_geom_pkg.sv
ctrl_pkg.sv
cache_way.sv
main_mem.sv
cache_ctrl.sv
mem_system.sv
tb_clkgen.sv
mem_system_chk.sv
tb_mem_system.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
fail_msg="Simulation failed"

verilator --binary --timing --assert --top-module tb_mem_system -f vlog.f -o tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "$fail_msg" "$log"; then
	echo "Testbench reported failure"
	exit 1
fi

echo "Testbench reported no failure"
exit 0

// File: tb_mem_system.sv
`timescale 1ns/1ps

module tb_mem_system;

	localparam int max_reqs = 64;
	localparam int fields = 3;	// Opcode, address, data
	localparam int done_limit = 20;	// Cycles allowed per request
	localparam int sets = 2**mem_geom_pkg::index_w;

	logic clk;
	logic rst_n;
	logic rd;
	logic wr;
	logic [mem_geom_pkg::addr_w-1:0] addr;
	logic [mem_geom_pkg::data_w-1:0] wdata;
	logic [mem_geom_pkg::data_w-1:0] rdata;
	logic done;
	logic stall;
	logic hit;
	logic err;

	logic [mem_geom_pkg::data_w-1:0] stim [max_reqs*fields];
	int n_req = -1;
	int errors = 0;
	int tests_failed = 0;
	logic [15:0] lfsr = 16'd13414;

	// Reference model of the memory contents and the cache directory
	logic [mem_geom_pkg::data_w-1:0] ref_mem [mem_geom_pkg::mem_words];
	logic [mem_geom_pkg::tag_w-1:0] ref_tag [sets][mem_geom_pkg::num_ways];
	logic ref_valid [sets][mem_geom_pkg::num_ways];
	logic ref_dirty [sets][mem_geom_pkg::num_ways];
	logic ref_victim;

	tb_clkgen u_clkgen (.clk(clk), .rst_n(rst_n));

	mem_system DUT (
		.clk(clk), .rst_n(rst_n), .rd(rd), .wr(wr), .addr(addr), .wdata(wdata),
		.rdata(rdata), .done(done), .stall(stall), .hit(hit), .err(err)
	);

	function automatic logic lfsr_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ 16'hB400;	// Taps 16, 14, 13, 11
		return b;
	endfunction

	function automatic int idle_gap();
		int gap;
		gap = int'(lfsr_bit());
		gap = (gap << 1) | int'(lfsr_bit());	// Two bits give 0 to 3 cycles
		return gap;
	endfunction

	task automatic check_data(input logic [mem_geom_pkg::data_w-1:0] actual,
			input logic [mem_geom_pkg::data_w-1:0] expected);
		if (actual !== expected) begin
			$display("Mismatch at time %0t: rdata %h, expected %h", $time, actual, expected);
			errors++;
		end
	endtask

	task automatic check_flags(input logic act_hit, input logic act_err,
			input logic exp_hit, input logic exp_err);
		if (act_hit !== exp_hit || act_err !== exp_err) begin
			$display("Mismatch at time %0t: hit %b err %b, expected hit %b err %b",
				$time, act_hit, act_err, exp_hit, exp_err);
			errors++;
		end
	endtask

	task automatic check_stall(input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("Mismatch at time %0t: stall %b, expected %b", $time, actual, expected);
			errors++;
		end
	endtask

	task automatic check_latency(input int actual, input int expected);
		if (actual != expected) begin
			$display("Mismatch at time %0t: done after %0d cycles, expected %0d",
				$time, actual, expected);
			errors++;
		end
	endtask

	task automatic model_access(input ctrl_pkg::req_op_t op,
			input logic [mem_geom_pkg::addr_w-1:0] a, input logic [mem_geom_pkg::data_w-1:0] d,
			output logic exp_hit, output logic exp_err, output int exp_lat,
			output logic [mem_geom_pkg::data_w-1:0] exp_data);
		logic [mem_geom_pkg::index_w-1:0] idx;
		logic [mem_geom_pkg::tag_w-1:0] tg;
		int way;
		idx = a[10:3];
		tg = a[15:11];
		way = -1;
		exp_hit = 1'b0;
		exp_err = a[0];	// Misaligned requests touch nothing
		exp_lat = 1;
		exp_data = '0;
		if (!exp_err) begin
			ref_victim = ~ref_victim;	// Flips in the lookup, before alloc uses it
			for (int w = 0; w < mem_geom_pkg::num_ways; w++) begin
				if (ref_valid[idx][w] && ref_tag[idx][w] == tg)
					way = w;
			end
			exp_hit = (way >= 0);
			if (!exp_hit) begin
				way = !ref_valid[idx][0] ? 0 : !ref_valid[idx][1] ? 1 : int'(ref_victim);
				exp_lat = (ref_valid[idx][way] && ref_dirty[idx][way]) ? 13 : 9;
				ref_tag[idx][way] = tg;
				ref_valid[idx][way] = 1'b1;
				ref_dirty[idx][way] = 1'b0;
			end
			if (op == ctrl_pkg::op_write) begin
				ref_mem[a[15:1]] = d;
				ref_dirty[idx][way] = 1'b1;
			end
			exp_data = ref_mem[a[15:1]];
		end
	endtask

	task automatic run_request(input int n, input ctrl_pkg::req_op_t op,
			input logic [mem_geom_pkg::addr_w-1:0] a, input logic [mem_geom_pkg::data_w-1:0] d);
		int gap;
		int cycles;
		int errors_before;
		int exp_lat;
		logic exp_hit;
		logic exp_err;
		logic [mem_geom_pkg::data_w-1:0] exp_data;
		errors_before = errors;
		gap = idle_gap();
		@(negedge clk);
		repeat (gap) @(negedge clk);
		check_stall(stall, 1'b0);	// Idle before the strobe
		rd = (op == ctrl_pkg::op_read);
		wr = (op == ctrl_pkg::op_write);
		addr = a;
		wdata = (op == ctrl_pkg::op_write) ? d : '0;
		model_access(op, a, d, exp_hit, exp_err, exp_lat, exp_data);
		@(negedge clk);
		rd = 1'b0;	// Strobe lasts one cycle
		wr = 1'b0;
		cycles = 1;
		while (!done && cycles < done_limit) begin
			check_stall(stall, 1'b1);
			@(negedge clk);
			cycles++;
		end
		if (!done) begin
			$display("Request %0d to address %h never raised done", n, a);
			errors++;
		end else begin
			check_stall(stall, 1'b1);	// Held through the done cycle
			check_latency(cycles, exp_lat);
			check_flags(hit, err, exp_hit, exp_err);
			if (op == ctrl_pkg::op_read && !exp_err) begin
				if (d !== exp_data) begin
					$display("Data file expects %h at address %h but the model holds %h",
						d, a, exp_data);
					errors++;
				end
				check_data(rdata, exp_data);
			end
		end
		if (errors != errors_before)
			tests_failed++;
		$display("Test %0d: %s %h %s", n, op.name(), a,
			(errors == errors_before) ? "ok" : "FAIL");
	endtask

	initial begin
		int i;
		ctrl_pkg::req_op_t op;
		rd = 1'b0;
		wr = 1'b0;
		addr = '0;
		wdata = '0;
		for (i = 0; i < max_reqs * fields; i++)
			stim[i] = '1;	// All ones marks the end of the list
		$readmemh("mem_system_testdata.txt", stim);
		for (i = 0; i < mem_geom_pkg::mem_words; i++)
			ref_mem[i] = '0;
		for (i = 0; i < sets; i++) begin
			for (int w = 0; w < mem_geom_pkg::num_ways; w++) begin
				ref_tag[i][w] = '0;
				ref_valid[i][w] = 1'b0;
				ref_dirty[i][w] = 1'b0;
			end
		end
		ref_victim = 1'b0;
		i = 0;
		while (i < max_reqs && stim[i*fields] !== '1)
			i++;
		n_req = i;
		if (n_req == 0) begin
			$display("The data file holds no requests");
			errors++;
		end
		wait (rst_n === 1'b1);
		for (i = 0; i < n_req; i++) begin
			op = ctrl_pkg::req_op_t'(stim[i*fields][1:0]);
			if (op == ctrl_pkg::op_read || op == ctrl_pkg::op_write) begin
				run_request(i + 1, op, stim[i*fields+1], stim[i*fields+2]);
			end else begin
				$display("Test %0d: entry has no read or write opcode", i + 1);
				errors++;
				tests_failed++;
			end
		end
		$display("Summary: %0d tests, %0d passed, %0d failed, %0d check errors",
			n_req, n_req - tests_failed, tests_failed, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// Watchdog sized from the request count
	initial begin
		wait (n_req >= 0);
		repeat (n_req * done_limit + 100) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", n_req * done_limit + 100);
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: mem_system_chk.sv
`timescale 1ns/1ps

module mem_system_chk (
	input logic clk,
	input logic rst_n,
	input logic done,
	input logic stall,
	input logic err
);

	// Completion is a one-cycle pulse
	a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
		else $error("done stayed high for more than one cycle");

	// The controller is idle right after a reset cycle
	a_stall_reset: assert property (@(posedge clk) !rst_n |=> !stall)
		else $error("stall is high after reset");

	a_err_done: assert property (@(posedge clk) disable iff (!rst_n) err |-> done)
		else $error("err is high without done");

endmodule

bind mem_system mem_system_chk u_chk (
	.clk(clk),
	.rst_n(rst_n),
	.done(done),
	.stall(stall),
	.err(err)
);

// File: tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
	parameter int period = 100,
	parameter int reset_cycles = 5
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;	// Released on a falling edge like all stimulus
	end

endmodule

// File: mem_system.sv
`timescale 1ns/1ps

module mem_system (
	input  logic clk,
	input  logic rst_n,
	input  logic rd,
	input  logic wr,
	input  logic [mem_geom_pkg::addr_w-1:0] addr,
	input  logic [mem_geom_pkg::data_w-1:0] wdata,
	output logic [mem_geom_pkg::data_w-1:0] rdata,
	output logic done,
	output logic stall,
	output logic hit,
	output logic err
);

	logic [mem_geom_pkg::addr_w-1:0] addr_q;
	logic [mem_geom_pkg::data_w-1:0] wdata_q;
	logic [mem_geom_pkg::num_ways-1:0] way_en;
	logic [mem_geom_pkg::num_ways-1:0] way_hit;
	logic [mem_geom_pkg::num_ways-1:0] way_valid;
	logic [mem_geom_pkg::num_ways-1:0] way_dirty;
	logic [mem_geom_pkg::tag_w-1:0] way_tag [mem_geom_pkg::num_ways];
	logic [mem_geom_pkg::data_w-1:0] way_rdata [mem_geom_pkg::num_ways];
	logic [mem_geom_pkg::offset_w-1:0] cache_offset;
	logic [mem_geom_pkg::offset_w-1:0] mem_offset;
	logic comp;
	logic way_write;
	logic tag_src;
	logic data_src;
	logic mem_rd;
	logic mem_wr;
	logic [mem_geom_pkg::data_w-1:0] mem_rdata;
	logic [mem_geom_pkg::data_w-1:0] way_wdata;
	logic [mem_geom_pkg::index_w-1:0] req_index;
	logic [mem_geom_pkg::tag_w-1:0] req_tag;
	logic [mem_geom_pkg::tag_w-1:0] mem_tag;
	logic victim_sel;

	assign req_index = addr_q[mem_geom_pkg::offset_w +: mem_geom_pkg::index_w];
	assign req_tag = addr_q[mem_geom_pkg::offset_w+mem_geom_pkg::index_w +: mem_geom_pkg::tag_w];

	assign way_wdata = data_src ? mem_rdata : wdata_q;	// Fill or request data
	assign victim_sel = way_en[1];	// Only one way enabled outside compare
	assign mem_tag = tag_src ? way_tag[victim_sel] : req_tag;
	assign rdata = way_hit[1] ? way_rdata[1] : way_rdata[0];

	cache_ctrl u_ctrl (
		.clk(clk), .rst_n(rst_n), .rd(rd), .wr(wr), .addr(addr), .wdata(wdata),
		.way_hit(way_hit), .way_valid(way_valid), .way_dirty(way_dirty),
		.addr_q(addr_q), .wdata_q(wdata_q), .way_en(way_en),
		.cache_offset(cache_offset), .mem_offset(mem_offset),
		.comp(comp), .way_write(way_write), .tag_src(tag_src), .data_src(data_src),
		.mem_rd(mem_rd), .mem_wr(mem_wr),
		.done(done), .stall(stall), .hit(hit), .err(err)
	);

	for (genvar w = 0; w < mem_geom_pkg::num_ways; w++) begin : g_way
		cache_way u_way (
			.clk(clk), .rst_n(rst_n), .en(way_en[w]), .comp(comp), .write(way_write),
			.index(req_index), .tag_in(req_tag), .offset(cache_offset),
			.wdata(way_wdata), .set_dirty(comp),	// Dirty on compare writes only
			.hit(way_hit[w]), .valid(way_valid[w]), .dirty(way_dirty[w]),
			.tag_out(way_tag[w]), .rdata(way_rdata[w])
		);
	end

	main_mem u_mem (
		.clk(clk), .rd(mem_rd), .wr(mem_wr),
		.addr({mem_tag, req_index}), .offset(mem_offset),
		.wdata(way_rdata[victim_sel]), .rdata(mem_rdata)
	);

endmodule

// File: cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl (
	input  logic clk,
	input  logic rst_n,
	input  logic rd,
	input  logic wr,
	input  logic [mem_geom_pkg::addr_w-1:0] addr,
	input  logic [mem_geom_pkg::data_w-1:0] wdata,
	input  logic [mem_geom_pkg::num_ways-1:0] way_hit,
	input  logic [mem_geom_pkg::num_ways-1:0] way_valid,
	input  logic [mem_geom_pkg::num_ways-1:0] way_dirty,
	output logic [mem_geom_pkg::addr_w-1:0] addr_q,
	output logic [mem_geom_pkg::data_w-1:0] wdata_q,
	output logic [mem_geom_pkg::num_ways-1:0] way_en,
	output logic [mem_geom_pkg::offset_w-1:0] cache_offset,
	output logic [mem_geom_pkg::offset_w-1:0] mem_offset,
	output logic comp,
	output logic way_write,
	output logic tag_src,
	output logic data_src,
	output logic mem_rd,
	output logic mem_wr,
	output logic done,
	output logic stall,
	output logic hit,
	output logic err
);

	ctrl_pkg::ctrl_state_t state;
	ctrl_pkg::ctrl_state_t next_state;
	ctrl_pkg::req_op_t op_q;
	logic victim;		// Global replacement bit
	logic way_sel;		// Way picked in alloc
	logic fill_way;
	logic misaligned;

	function automatic logic [mem_geom_pkg::num_ways-1:0] onehot(input logic w);
		onehot = '0;
		onehot[w] = 1'b1;
	endfunction

	function automatic logic [mem_geom_pkg::offset_w-1:0] word_off(input logic [1:0] w);
		return {w, 1'b0};
	endfunction

	assign misaligned = addr_q[0];
	assign fill_way = !way_valid[0] ? 1'b0 : !way_valid[1] ? 1'b1 : victim;
	assign stall = (state != ctrl_pkg::idle);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ctrl_pkg::idle;
			op_q <= ctrl_pkg::op_none;
			victim <= 1'b0;
			way_sel <= 1'b0;
		end else begin
			state <= next_state;
			if (state == ctrl_pkg::idle) begin
				if (wr)
					op_q <= ctrl_pkg::op_write;	// Write wins if both
				else if (rd)
					op_q <= ctrl_pkg::op_read;
				else
					op_q <= ctrl_pkg::op_none;
			end
			if (state == ctrl_pkg::compare && !misaligned)
				victim <= ~victim;
			if (state == ctrl_pkg::alloc)
				way_sel <= fill_way;
		end
	end

	always_ff @(posedge clk) begin
		if (state == ctrl_pkg::idle) begin
			addr_q <= addr;
			wdata_q <= wdata;
		end
	end

	always_comb begin
		next_state = state;
		way_en = onehot(way_sel);
		cache_offset = addr_q[mem_geom_pkg::offset_w-1:0];
		mem_offset = '0;
		comp = 1'b0;
		way_write = 1'b0;
		tag_src = 1'b0;
		data_src = 1'b0;
		mem_rd = 1'b0;
		mem_wr = 1'b0;
		done = 1'b0;
		hit = 1'b0;
		err = 1'b0;
		case (state)
		ctrl_pkg::idle: begin
			way_en = '0;
			if (rd || wr)
				next_state = ctrl_pkg::compare;
		end
		ctrl_pkg::compare: begin
			way_en = '1;	// Look up both ways
			comp = 1'b1;
			if (misaligned) begin
				done = 1'b1;
				err = 1'b1;
				next_state = ctrl_pkg::idle;
			end else begin
				way_write = (op_q == ctrl_pkg::op_write);
				if (|way_hit) begin
					done = 1'b1;
					hit = 1'b1;
					next_state = ctrl_pkg::idle;
				end else begin
					next_state = ctrl_pkg::alloc;
				end
			end
		end
		ctrl_pkg::alloc: begin
			way_en = onehot(fill_way);
			if (way_valid[fill_way] && way_dirty[fill_way])
				next_state = ctrl_pkg::wb_0;
			else
				next_state = ctrl_pkg::req_0;
		end
		ctrl_pkg::wb_0: begin
			cache_offset = word_off(2'd0);
			mem_offset = word_off(2'd0);
			mem_wr = 1'b1;
			tag_src = 1'b1;	// Victim tag to memory
			next_state = ctrl_pkg::wb_1;
		end
		ctrl_pkg::wb_1: begin
			cache_offset = word_off(2'd1);
			mem_offset = word_off(2'd1);
			mem_wr = 1'b1;
			tag_src = 1'b1;
			next_state = ctrl_pkg::wb_2;
		end
		ctrl_pkg::wb_2: begin
			cache_offset = word_off(2'd2);
			mem_offset = word_off(2'd2);
			mem_wr = 1'b1;
			tag_src = 1'b1;
			next_state = ctrl_pkg::wb_3;
		end
		ctrl_pkg::wb_3: begin
			cache_offset = word_off(2'd3);
			mem_offset = word_off(2'd3);
			mem_wr = 1'b1;
			tag_src = 1'b1;
			next_state = ctrl_pkg::req_0;
		end
		ctrl_pkg::req_0: begin
			mem_offset = word_off(2'd0);
			mem_rd = 1'b1;
			next_state = ctrl_pkg::req_1;
		end
		ctrl_pkg::req_1: begin
			mem_offset = word_off(2'd1);
			mem_rd = 1'b1;
			next_state = ctrl_pkg::req_2_fill_0;
		end
		ctrl_pkg::req_2_fill_0: begin
			mem_offset = word_off(2'd2);
			mem_rd = 1'b1;
			cache_offset = word_off(2'd0);	// Word 0 arrives now
			way_write = 1'b1;
			data_src = 1'b1;
			next_state = ctrl_pkg::req_3_fill_1;
		end
		ctrl_pkg::req_3_fill_1: begin
			mem_offset = word_off(2'd3);
			mem_rd = 1'b1;
			cache_offset = word_off(2'd1);
			way_write = 1'b1;
			data_src = 1'b1;
			next_state = ctrl_pkg::fill_2;
		end
		ctrl_pkg::fill_2: begin
			cache_offset = word_off(2'd2);
			way_write = 1'b1;
			data_src = 1'b1;
			next_state = ctrl_pkg::fill_3;
		end
		ctrl_pkg::fill_3: begin
			cache_offset = word_off(2'd3);
			way_write = 1'b1;
			data_src = 1'b1;
			next_state = ctrl_pkg::finish;
		end
		ctrl_pkg::finish: begin
			comp = 1'b1;	// Line now hits, replay the access
			way_write = (op_q == ctrl_pkg::op_write);
			done = 1'b1;
			next_state = ctrl_pkg::idle;
		end
		default: next_state = ctrl_pkg::idle;
		endcase
	end

endmodule

// File: main_mem.sv
`timescale 1ns/1ps

module main_mem (
	input  logic clk,
	input  logic rd,
	input  logic wr,
	input  logic [mem_geom_pkg::tag_w+mem_geom_pkg::index_w-1:0] addr,
	input  logic [mem_geom_pkg::offset_w-1:0] offset,
	input  logic [mem_geom_pkg::data_w-1:0] wdata,
	output logic [mem_geom_pkg::data_w-1:0] rdata
);

	logic [mem_geom_pkg::offset_w-2:0] bank_sel;
	logic [mem_geom_pkg::data_w-1:0] bank_rdata [mem_geom_pkg::words_per_line];
	logic [mem_geom_pkg::data_w-1:0] rd_pipe [mem_geom_pkg::mem_latency];

	assign bank_sel = offset[mem_geom_pkg::offset_w-1:1];	// Word within line

	// One bank per word position, all share the line address
	for (genvar b = 0; b < mem_geom_pkg::words_per_line; b++) begin : g_bank
		logic [mem_geom_pkg::data_w-1:0]
			cells [mem_geom_pkg::mem_words/mem_geom_pkg::words_per_line] = '{default: '0};

		always_ff @(posedge clk) begin
			if (wr && bank_sel == 2'(b))
				cells[addr] <= wdata;	// Writes land at once
		end

		assign bank_rdata[b] = cells[addr];
	end

	// Read data walks through mem_latency stages, so reads may overlap
	always_ff @(posedge clk) begin
		rd_pipe[0] <= rd ? bank_rdata[bank_sel] : '0;
		for (int s = 1; s < mem_geom_pkg::mem_latency; s++) begin
			rd_pipe[s] <= rd_pipe[s-1];
		end
	end

	assign rdata = rd_pipe[mem_geom_pkg::mem_latency-1];

endmodule

// File: cache_way.sv
`timescale 1ns/1ps

module cache_way (
	input  logic clk,
	input  logic rst_n,
	input  logic en,
	input  logic comp,
	input  logic write,
	input  logic [mem_geom_pkg::index_w-1:0] index,
	input  logic [mem_geom_pkg::tag_w-1:0] tag_in,
	input  logic [mem_geom_pkg::offset_w-1:0] offset,
	input  logic [mem_geom_pkg::data_w-1:0] wdata,
	input  logic set_dirty,
	output logic hit,
	output logic valid,
	output logic dirty,
	output logic [mem_geom_pkg::tag_w-1:0] tag_out,
	output logic [mem_geom_pkg::data_w-1:0] rdata
);

	logic [mem_geom_pkg::data_w-1:0] data_mem [2**(mem_geom_pkg::index_w+2)];
	logic [mem_geom_pkg::tag_w-1:0] tag_mem [2**mem_geom_pkg::index_w];
	logic [2**mem_geom_pkg::index_w-1:0] valid_bits;
	logic [2**mem_geom_pkg::index_w-1:0] dirty_bits;
	logic [mem_geom_pkg::index_w+1:0] word_addr;
	logic do_write;

	assign word_addr = {index, offset[mem_geom_pkg::offset_w-1:1]};	// Byte bit dropped

	assign valid = valid_bits[index];
	assign dirty = dirty_bits[index];
	assign tag_out = tag_mem[index];
	assign rdata = data_mem[word_addr];
	assign hit = en & valid & (tag_out == tag_in);

	// Compare writes only land on a hit, access writes always land
	assign do_write = en & write & (comp ? hit : 1'b1);

	always_ff @(posedge clk) begin
		if (do_write) begin
			data_mem[word_addr] <= wdata;
			if (!comp)
				tag_mem[index] <= tag_in;	// New line on fill
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end else if (do_write) begin
			if (!comp)
				valid_bits[index] <= 1'b1;
			dirty_bits[index] <= set_dirty;	// Fill leaves the line clean
		end
	end

endmodule

// File: ctrl_pkg.sv
package ctrl_pkg;

	typedef enum logic [3:0] {
		idle,		// Waiting for a strobe
		compare,	// Tag lookup in both ways
		alloc,		// Pick the fill way
		wb_0,		// Write back word 0
		wb_1,
		wb_2,
		wb_3,
		req_0,		// Memory read word 0
		req_1,
		req_2_fill_0,	// Read word 2, write word 0 into way
		req_3_fill_1,	// Read word 3, write word 1 into way
		fill_2,
		fill_3,
		finish		// Replay access on the filled line
	} ctrl_state_t;

	typedef enum logic [1:0] {
		op_none,
		op_read,
		op_write
	} req_op_t;

endpackage

// File: mem_geom_pkg.sv
package mem_geom_pkg;

	// Request side
	localparam int addr_w = 16;	// Byte address
	localparam int data_w = 16;	// One word

	// Address split, tag | index | offset
	localparam int offset_w = 3;	// Byte offset within a line
	localparam int index_w = 8;	// Set index, addr[10:3]
	localparam int tag_w = 5;	// Tag, addr[15:11]

	// Cache organization
	localparam int num_ways = 2;
	localparam int words_per_line = 4;	// Words at byte offsets 0, 2, 4, 6

	// Main memory model
	localparam int mem_latency = 2;	// Cycles from rd to rdata
	localparam int mem_words = 32768;	// Full 64 KB space in words

endpackage
